// File: source/mf2_consts.svh
// Multiface Two constants
`ifndef MF2_CONSTS_SVH
`define MF2_CONSTS_SVH

// Bus widths
`define MF2_ADDR_W 16
`define MF2_DATA_W 8
`define MF2_RAM_AW 13

// Paging port FEE8/FEEA, compared against cpu_addr[15:2]
`define MF2_PAGE_PORT 14'b11111110111010

// Opcode fetch addresses
`define MF2_NMI_VECTOR 16'h0066
`define MF2_HIDE_VECTOR 16'h0065

// Memory windows, values of cpu_addr[15:13]
`define MF2_ROM_AREA 3'b000
`define MF2_RAM_AREA 3'b001

// Shadow store addresses in expansion RAM
`define MF2_ST_PEN 13'h1FCF
`define MF2_ST_PALETTE_BASE 13'h1F90
`define MF2_ST_BORDER 13'h1FDF
`define MF2_ST_MODE 13'h1FEF
`define MF2_ST_BANK 13'h1FFF
`define MF2_ST_CRTC_SEL 13'h1CFF
`define MF2_ST_CRTC_BASE 13'h1DB0
`define MF2_ST_PPI 13'h17FF
`define MF2_ST_ROMSEL 13'h1AAC

// High port bytes
`define MF2_PORT_GA 8'h7F
`define MF2_PORT_CRTC_SEL 8'hBC
`define MF2_PORT_CRTC_DAT 8'hBD
`define MF2_PORT_PPI 8'hF7
`define MF2_PORT_ROMSEL 8'hDF

`endif

// File: source/mf2_pkg.sv
// Multiface Two types
package mf2_pkg;

	// Power-up mode
	typedef enum logic [1:0] {
		MODE_ENABLED  = 2'd0,
		MODE_HIDDEN   = 2'd1,
		MODE_DISABLED = 2'd2
	} mf2_mode_t;

	// Paging state
	typedef enum logic [1:0] {
		ST_IDLE        = 2'd0,
		ST_NMI_PENDING = 2'd1,
		ST_PAGED       = 2'd2
	} mf2_state_t;

	// Class of an I/O write
	typedef enum logic [3:0] {
		PORT_NONE     = 4'd0,
		PORT_PEN      = 4'd1,
		PORT_COLOR    = 4'd2,
		PORT_MODE     = 4'd3,
		PORT_BANK     = 4'd4,
		PORT_CRTC_SEL = 4'd5,
		PORT_CRTC_VAL = 4'd6,
		PORT_PPI      = 4'd7,
		PORT_ROMSEL   = 4'd8,
		PORT_PAGING   = 4'd9
	} mf2_port_t;

endpackage

// File: source/mf2_io_if.sv
// Decoded I/O write bus
`include "mf2_consts.svh"

interface mf2_io_if;
	import mf2_pkg::*;

	// One-cycle strobe per I/O write
	logic port_stb;
	mf2_port_t port_class;
	// Only meaningful with PORT_PAGING
	logic page_in;
	logic [`MF2_RAM_AW-1:0] store_addr;
	logic [`MF2_DATA_W-1:0] store_data;

	modport decode (
		output port_stb,
		output port_class,
		output page_in,
		output store_addr,
		output store_data
	);

	modport control (
		input port_stb,
		input port_class,
		input page_in
	);

	modport ram (
		input port_stb,
		input port_class,
		input store_addr,
		input store_data
	);

endinterface

// File: source/mf2_io_decode.sv
// I/O write decoder
`include "mf2_consts.svh"

module mf2_io_decode (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic [`MF2_ADDR_W-1:0] cpu_addr,
	input  logic [`MF2_DATA_W-1:0] cpu_dout,
	input  logic                   io_wr,
	mf2_io_if.decode               bus
);
	import mf2_pkg::*;

	logic io_wr_q;
	logic io_wr_rise;
	logic [4:0] pen_idx;
	logic [3:0] crtc_reg;
	logic [7:0] hi_byte;
	mf2_port_t port_class_c;
	logic [`MF2_RAM_AW-1:0] store_addr_c;

	assign hi_byte = cpu_addr[15:8];
	assign io_wr_rise = io_wr & ~io_wr_q;

	////////////////////
	// Port classification

	always_comb begin
		port_class_c = PORT_NONE;
		if (cpu_addr[15:2] == `MF2_PAGE_PORT) begin
			port_class_c = PORT_PAGING;
		end else begin
			case (hi_byte)
				// Gate Array function lives in the top data bits
				`MF2_PORT_GA: begin
					case (cpu_dout[7:6])
						2'b00: port_class_c = PORT_PEN;
						2'b01: port_class_c = PORT_COLOR;
						2'b10: port_class_c = PORT_MODE;
						default: port_class_c = PORT_BANK;
					endcase
				end
				`MF2_PORT_CRTC_SEL: port_class_c = PORT_CRTC_SEL;
				`MF2_PORT_CRTC_DAT: port_class_c = PORT_CRTC_VAL;
				`MF2_PORT_PPI: port_class_c = PORT_PPI;
				`MF2_PORT_ROMSEL: port_class_c = PORT_ROMSEL;
				default: port_class_c = PORT_NONE;
			endcase
		end
	end

	// Pen index bit 4 selects the border entry
	always_comb begin
		case (port_class_c)
			PORT_PEN: store_addr_c = `MF2_ST_PEN;
			PORT_COLOR: store_addr_c = pen_idx[4] ? `MF2_ST_BORDER :
				(`MF2_ST_PALETTE_BASE | {9'd0, pen_idx[3:0]});
			PORT_MODE: store_addr_c = `MF2_ST_MODE;
			PORT_BANK: store_addr_c = `MF2_ST_BANK;
			PORT_CRTC_SEL: store_addr_c = `MF2_ST_CRTC_SEL;
			PORT_CRTC_VAL: store_addr_c = `MF2_ST_CRTC_BASE | {9'd0, crtc_reg};
			PORT_PPI: store_addr_c = `MF2_ST_PPI;
			PORT_ROMSEL: store_addr_c = `MF2_ST_ROMSEL;
			default: store_addr_c = '0;
		endcase
	end

	////////////////////
	// Strobe and tracked registers

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_q <= 1'b0;
			bus.port_stb <= 1'b0;
			bus.port_class <= PORT_NONE;
			pen_idx <= '0;
			crtc_reg <= '0;
		end else begin
			io_wr_q <= io_wr;
			bus.port_stb <= io_wr_rise;
			if (io_wr_rise) begin
				bus.port_class <= port_class_c;
				if (port_class_c == PORT_PEN)
					pen_idx <= cpu_dout[4:0];
				if (port_class_c == PORT_CRTC_SEL)
					crtc_reg <= cpu_dout[3:0];
			end
		end
	end

	// Store payload
	always_ff @(posedge clk_sys) begin
		if (io_wr_rise) begin
			bus.store_addr <= store_addr_c;
			bus.store_data <= cpu_dout;
			bus.page_in <= ~cpu_addr[1];
		end
	end

endmodule

// File: source/mf2_control.sv
// NMI and paging control
`include "mf2_consts.svh"

module mf2_control (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  mf2_pkg::mf2_mode_t     mode,
	input  logic [`MF2_ADDR_W-1:0] cpu_addr,
	input  logic                   m1,
	input  logic                   key_nmi,
	mf2_io_if.control              bus,
	output logic                   nmi,
	output logic                   paged
);
	import mf2_pkg::*;

	mf2_state_t state;
	logic hidden;
	logic key_q;
	logic m1_q;
	logic key_rise;
	logic m1_rise;
	logic page_stb;

	assign key_rise = key_nmi & ~key_q;
	assign m1_rise = m1 & ~m1_q;
	assign page_stb = bus.port_stb && (bus.port_class == PORT_PAGING);

	////////////////////
	// State machine

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state <= ST_IDLE;
			hidden <= (mode != MODE_ENABLED);
			key_q <= 1'b0;
			m1_q <= 1'b0;
		end else begin
			key_q <= key_nmi;
			m1_q <= m1;

			case (state)
				ST_IDLE: begin
					if (key_rise && mode != MODE_DISABLED)
						state <= ST_NMI_PENDING;
				end
				// Fetch of the NMI vector pages us in
				ST_NMI_PENDING: begin
					if (m1_rise && cpu_addr == `MF2_NMI_VECTOR) begin
						state <= ST_PAGED;
						hidden <= 1'b0;
					end
				end
				ST_PAGED: begin
					if (m1_rise && cpu_addr == `MF2_HIDE_VECTOR)
						hidden <= 1'b1;
				end
				default: state <= ST_IDLE;
			endcase

			// Port write overrides the fetch logic; FEEA pages out
			if (page_stb) begin
				if (bus.page_in && !hidden)
					state <= ST_PAGED;
				else if (state == ST_PAGED)
					state <= ST_IDLE;
			end
		end
	end

	assign nmi = (state == ST_NMI_PENDING);
	assign paged = (state == ST_PAGED);

endmodule

// File: source/mf2_shadow_ram.sv
// Expansion RAM with shadow stores
`include "mf2_consts.svh"

module mf2_shadow_ram (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   paged,
	input  logic [`MF2_ADDR_W-1:0] cpu_addr,
	input  logic [`MF2_DATA_W-1:0] cpu_dout,
	input  logic                   mem_rd,
	input  logic                   mem_wr,
	mf2_io_if.ram                  bus,
	output logic                   rom_en,
	output logic                   ram_en,
	output logic [`MF2_DATA_W-1:0] cpu_din
);
	import mf2_pkg::*;

	logic [`MF2_DATA_W-1:0] mem [1 << `MF2_RAM_AW];
	logic [`MF2_RAM_AW-1:0] ram_a;
	logic [`MF2_DATA_W-1:0] ram_in;
	logic [`MF2_DATA_W-1:0] ram_out;
	logic ram_we;
	logic store_hit;

	// Windows only exist while paged
	assign rom_en = paged && (cpu_addr[15:13] == `MF2_ROM_AREA);
	assign ram_en = paged && (cpu_addr[15:13] == `MF2_RAM_AREA);

	assign store_hit = bus.port_stb && (bus.port_class != PORT_NONE) &&
		(bus.port_class != PORT_PAGING);

	////////////////////
	// Port arbitration with stores first

	always_ff @(posedge clk_sys) begin
		if (reset)
			ram_we <= 1'b0;
		else
			ram_we <= store_hit || (mem_wr && ram_en);
	end

	always_ff @(posedge clk_sys) begin
		if (store_hit) begin
			ram_a <= bus.store_addr;
			ram_in <= bus.store_data;
		end else begin
			ram_a <= cpu_addr[`MF2_RAM_AW-1:0];
			ram_in <= cpu_dout;
		end
	end

	// Write data passes through to the read register
	always_ff @(posedge clk_sys) begin
		if (ram_we) begin
			mem[ram_a] <= ram_in;
			ram_out <= ram_in;
		end else begin
			ram_out <= mem[ram_a];
		end
	end

	// Open bus reads as all ones
	assign cpu_din = (ram_en && mem_rd) ? ram_out : 8'hFF;

endmodule

// File: source/mf2_top.sv
// Multiface Two top level
`include "mf2_consts.svh"

module mf2_top (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  mf2_pkg::mf2_mode_t     mode,
	input  logic [`MF2_ADDR_W-1:0] cpu_addr,
	input  logic [`MF2_DATA_W-1:0] cpu_dout,
	input  logic                   io_wr,
	input  logic                   mem_rd,
	input  logic                   mem_wr,
	input  logic                   m1,
	input  logic                   key_nmi,
	output logic                   nmi,
	output logic                   paged,
	output logic                   rom_en,
	output logic                   ram_en,
	output logic [`MF2_DATA_W-1:0] cpu_din
);

	mf2_io_if i_bus ();

	mf2_io_decode i_decode (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.cpu_addr (cpu_addr),
		.cpu_dout (cpu_dout),
		.io_wr    (io_wr),
		.bus      (i_bus.decode)
	);

	mf2_control i_control (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.mode     (mode),
		.cpu_addr (cpu_addr),
		.m1       (m1),
		.key_nmi  (key_nmi),
		.bus      (i_bus.control),
		.nmi      (nmi),
		.paged    (paged)
	);

	mf2_shadow_ram i_ram (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.paged    (paged),
		.cpu_addr (cpu_addr),
		.cpu_dout (cpu_dout),
		.mem_rd   (mem_rd),
		.mem_wr   (mem_wr),
		.bus      (i_bus.ram),
		.rom_en   (rom_en),
		.ram_en   (ram_en),
		.cpu_din  (cpu_din)
	);

endmodule

// File: bench/mf2_assertions.sv
// Multiface Two assertions
module mf2_assertions (
	input logic                clk_sys,
	input logic                reset,
	input mf2_pkg::mf2_state_t state,
	input logic                nmi,
	input logic                paged,
	input logic                rom_en,
	input logic                ram_en,
	input logic                port_stb
);
	import mf2_pkg::*;

	// NMI request only ends by paging the expansion in
	a_nmi_drop: assert property (@(posedge clk_sys) disable iff (reset)
		$fell(nmi) |-> state == ST_PAGED)
		else $error("nmi fell without the expansion paging in");

	a_stb_width: assert property (@(posedge clk_sys) disable iff (reset)
		port_stb |=> !port_stb)
		else $error("port_stb longer than one cycle");

	// Windows are exclusive and only open while paged
	a_win_excl: assert property (@(posedge clk_sys) disable iff (reset)
		!(rom_en && ram_en))
		else $error("rom_en and ram_en both high");

	a_ram_paged: assert property (@(posedge clk_sys) disable iff (reset)
		ram_en |-> paged)
		else $error("ram_en high while not paged");

endmodule

bind mf2_top mf2_assertions i_assertions (
	.clk_sys  (clk_sys),
	.reset    (reset),
	.state    (i_control.state),
	.nmi      (nmi),
	.paged    (paged),
	.rom_en   (rom_en),
	.ram_en   (ram_en),
	.port_stb (i_bus.port_stb)
);

// File: bench/mf2_tb.sv
// Multiface Two testbench
`include "mf2_consts.svh"

module mf2_tb;
	import mf2_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 8;
	// Four held cycles plus one idle cycle between operations
	localparam int OP_CYCLES = 5;
	localparam int N_IO = 48;
	localparam int N_MEM = 120;
	localparam int N_FIXED = 40;
	localparam int N_OPS = 2 * N_IO + N_MEM + N_FIXED;
	localparam int TIMEOUT = (N_OPS * OP_CYCLES + 4 * (RESET_CYCLES + 2) + 100) * CLK_PERIOD;

	localparam int OP_IO = 0;
	localparam int OP_WR = 1;
	localparam int OP_RD = 2;
	localparam int OP_M1 = 3;
	localparam int OP_KEY = 4;

	logic clk_sys = 1'b0;
	logic reset;
	mf2_mode_t mode;
	logic [15:0] cpu_addr;
	logic [7:0] cpu_dout;
	logic io_wr;
	logic mem_rd;
	logic mem_wr;
	logic m1;
	logic key_nmi;
	logic nmi;
	logic paged;
	logic rom_en;
	logic ram_en;
	logic [7:0] cpu_din;

	// Reference model state
	logic [7:0] model_mem [8192];
	bit known [8192];
	logic [12:0] known_q [$];
	logic m_nmi;
	logic m_paged;
	logic m_hidden;
	logic [4:0] m_pen;
	logic [3:0] m_crtc;
	mf2_mode_t m_mode;
	logic [7:0] io_ports [6] = '{8'h7F, 8'hBC, 8'hBD, 8'hF7, 8'hDF, 8'h10};

	mf2_top i_dut (.*);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	////////////////////
	// Checking

	task automatic check_value(input string what, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("FAIL %0t: %s is %02h, expected %02h", $time, what, got, exp);
			$display("Test failures found");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic check_outputs();
		check_value("nmi", 8'(nmi), 8'(m_nmi));
		check_value("paged", 8'(paged), 8'(m_paged));
		check_value("rom_en", 8'(rom_en), 8'(m_paged && cpu_addr[15:13] == `MF2_ROM_AREA));
		check_value("ram_en", 8'(ram_en), 8'(m_paged && cpu_addr[15:13] == `MF2_RAM_AREA));
	endtask

	////////////////////
	// Reference model

	task automatic model_store(input logic [12:0] a, input logic [7:0] d);
		model_mem[a] = d;
		if (!known[a]) begin
			known[a] = 1'b1;
			known_q.push_back(a);
		end
	endtask

	task automatic model_io(input logic [15:0] addr, input logic [7:0] data);
		logic hit;
		logic [12:0] sa;
		hit = 1'b1;
		sa = '0;
		if (addr[15:2] == `MF2_PAGE_PORT) begin
			hit = 1'b0;
			// Only FEE8 with hidden clear pages in
			if (!addr[1] && !m_hidden) begin
				m_paged = 1'b1;
				m_nmi = 1'b0;
			end else begin
				m_paged = 1'b0;
			end
		end else begin
			case (addr[15:8])
				`MF2_PORT_GA: begin
					case (data[7:6])
						2'b00: begin
							m_pen = data[4:0];
							sa = `MF2_ST_PEN;
						end
						2'b01: sa = m_pen[4] ? `MF2_ST_BORDER :
							`MF2_ST_PALETTE_BASE + {9'd0, m_pen[3:0]};
						2'b10: sa = `MF2_ST_MODE;
						default: sa = `MF2_ST_BANK;
					endcase
				end
				`MF2_PORT_CRTC_SEL: begin
					m_crtc = data[3:0];
					sa = `MF2_ST_CRTC_SEL;
				end
				`MF2_PORT_CRTC_DAT: sa = `MF2_ST_CRTC_BASE + {9'd0, m_crtc};
				`MF2_PORT_PPI: sa = `MF2_ST_PPI;
				`MF2_PORT_ROMSEL: sa = `MF2_ST_ROMSEL;
				default: hit = 1'b0;
			endcase
		end
		if (hit)
			model_store(sa, data);
	endtask

	task automatic model_op(input int kind, input logic [15:0] addr, input logic [7:0] data);
		case (kind)
			OP_IO: model_io(addr, data);
			OP_WR: begin
				if (m_paged && addr[15:13] == `MF2_RAM_AREA)
					model_store(addr[12:0], data);
			end
			OP_M1: begin
				if (m_nmi && addr == `MF2_NMI_VECTOR) begin
					m_paged = 1'b1;
					m_nmi = 1'b0;
					m_hidden = 1'b0;
				end else if (m_paged && addr == `MF2_HIDE_VECTOR) begin
					m_hidden = 1'b1;
				end
			end
			OP_KEY: begin
				if (!m_nmi && !m_paged && m_mode != MODE_DISABLED)
					m_nmi = 1'b1;
			end
			default: ;
		endcase
	endtask

	////////////////////
	// Stimulus

	task automatic idle_inputs();
		io_wr <= 1'b0;
		mem_rd <= 1'b0;
		mem_wr <= 1'b0;
		m1 <= 1'b0;
		key_nmi <= 1'b0;
	endtask

	task automatic run_op(input int kind, input logic [15:0] addr, input logic [7:0] data);
		logic [7:0] exp_din;
		logic do_din;
		@(posedge clk_sys);
		idle_inputs();
		@(posedge clk_sys);
		cpu_addr <= addr;
		cpu_dout <= data;
		io_wr <= (kind == OP_IO);
		mem_wr <= (kind == OP_WR);
		mem_rd <= (kind == OP_RD);
		m1 <= (kind == OP_M1);
		key_nmi <= (kind == OP_KEY);
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		model_op(kind, addr, data);
		check_outputs();
		exp_din = 8'hFF;
		do_din = 1'b1;
		if (kind == OP_RD && m_paged && addr[15:13] == `MF2_RAM_AREA) begin
			exp_din = model_mem[addr[12:0]];
			do_din = known[addr[12:0]];
		end
		if (do_din)
			check_value("cpu_din", cpu_din, exp_din);
	endtask

	task automatic reset_dut(input mf2_mode_t m);
		@(posedge clk_sys);
		idle_inputs();
		reset <= 1'b1;
		mode <= m;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		reset <= 1'b0;
		m_mode = m;
		m_nmi = 1'b0;
		m_paged = 1'b0;
		m_hidden = (m != MODE_ENABLED);
		m_pen = '0;
		m_crtc = '0;
		@(negedge clk_sys);
		check_outputs();
		check_value("cpu_din", cpu_din, 8'hFF);
	endtask

	initial begin
		#(TIMEOUT);
		$display("ERROR: watchdog expired after %0d time units, the tests did not finish", TIMEOUT);
		$display("Test failures found");
		$fatal(1, "watchdog timeout");
	end

	initial begin
		logic [15:0] a;
		int sel;
		void'($urandom(55837));
		reset = 1'b1;
		mode = MODE_ENABLED;
		cpu_addr = '0;
		cpu_dout = '0;
		io_wr = 1'b0;
		mem_rd = 1'b0;
		mem_wr = 1'b0;
		m1 = 1'b0;
		key_nmi = 1'b0;

		reset_dut(MODE_ENABLED);
		run_op(OP_RD, 16'h2000, 8'h00);

		// Shadow stores while the expansion is still out
		for (int i = 0; i < N_IO; i++)
			run_op(OP_IO, {io_ports[$urandom_range(5, 0)], 8'($urandom())}, 8'($urandom()));

		// NMI entry, then read back every shadowed register
		run_op(OP_KEY, 16'h0000, 8'h00);
		run_op(OP_M1, `MF2_NMI_VECTOR, 8'h00);
		foreach (known_q[k])
			run_op(OP_RD, 16'h2000 | {3'b000, known_q[k]}, 8'h00);

		// Mixed memory traffic
		for (int i = 0; i < N_MEM; i++) begin
			sel = int'($urandom_range(3, 0));
			if (sel < 2) begin
				run_op(OP_WR, {3'b001, 13'($urandom())}, 8'($urandom()));
			end else if (sel == 2) begin
				a = 16'h2000 | {3'b000, known_q[$urandom_range(known_q.size() - 1, 0)]};
				run_op(OP_RD, a, 8'h00);
			end else begin
				a = 16'($urandom());
				if (a[15:13] == `MF2_RAM_AREA)
					a[15] = 1'b1;
				run_op(OP_RD, a, 8'h00);
			end
		end

		// Paging port, then hiding
		run_op(OP_IO, 16'hFEEA, 8'($urandom()));
		run_op(OP_RD, 16'h2000 | {3'b000, known_q[0]}, 8'h00);
		run_op(OP_IO, 16'hFEE8, 8'($urandom()));
		run_op(OP_RD, 16'h2000 | {3'b000, known_q[0]}, 8'h00);
		run_op(OP_M1, `MF2_HIDE_VECTOR, 8'h00);
		run_op(OP_IO, 16'hFEEA, 8'h00);
		run_op(OP_IO, 16'hFEE8, 8'h00);

		reset_dut(MODE_DISABLED);
		run_op(OP_KEY, 16'h0000, 8'h00);
		run_op(OP_M1, `MF2_NMI_VECTOR, 8'h00);
		run_op(OP_IO, 16'hFEE8, 8'h00);

		reset_dut(MODE_HIDDEN);
		run_op(OP_IO, 16'hFEE8, 8'h00);
		run_op(OP_KEY, 16'h0000, 8'h00);
		run_op(OP_M1, `MF2_NMI_VECTOR, 8'h00);
		run_op(OP_IO, 16'hFEEA, 8'h00);
		run_op(OP_IO, 16'hFEE8, 8'h00);

		$display("All tests passed!");
		$finish;
	end

endmodule

// File: vlog.f
+incdir+source
source/mf2_pkg.sv
source/mf2_io_if.sv
source/mf2_io_decode.sv
source/mf2_control.sv
source/mf2_shadow_ram.sv
source/mf2_top.sv
bench/mf2_assertions.sv
bench/mf2_tb.sv

// File: Makefile
# Verilator build and run for the Multiface Two testbench

VERILATOR ?= verilator
TOP       ?= mf2_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  := Test failures found

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# A crash or stop without the message still counts as a failure
run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; \
	else echo "Simulation PASSED"; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
